// File: compile.f
+incdir+common
+incdir+dv
common/rvPkg.sv
core/regFile.sv
core/fetchStage.sv
core/decodeStage.sv
core/hazardUnit.sv
core/executeStage.sv
core/memWbStage.sv
core/rvCore.sv
dv/rvCoreTb.sv

// File: dv/tbProgram.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// RV64I base formats
function automatic logic [31:0] rFormat(input logic [2:0] funct3, input logic [6:0] funct7,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2);
    return {funct7, rs2, rs1, funct3, rd, 7'h33};
endfunction

function automatic logic [31:0] iFormat(input logic [6:0] opcode, input logic [2:0] funct3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [11:0] imm);
    return {imm, rs1, funct3, rd, opcode};
endfunction

// sd is the only store kept
function automatic logic [31:0] sFormat(input logic [4:0] rs2, input logic [4:0] rs1,
                                        input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'd3, imm[4:0], 7'h23};
endfunction

function automatic logic [31:0] bFormat(input logic [2:0] funct3, input logic [4:0] rs1,
                                        input logic [4:0] rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], 7'h63};
endfunction

function automatic logic [31:0] jFormat(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6F};
endfunction

function automatic logic [31:0] uFormat(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, 7'h37};
endfunction

task automatic emit(input logic [31:0] word);
    rom[progPc / 4] = word;
    progPc += 4;
endtask

// Store into the next free slot and expect the given value there
task automatic checkedStore(input string name, input logic [4:0] rs2, input logic [63:0] value);
    emit(sFormat(rs2, 5'd0, 12'(storeSlot * 8)));
    expName[storeSlot] = name;
    expAddr[storeSlot] = `RAM_AW'(storeSlot);
    expData[storeSlot] = value;
    storeSlot++;
endtask

// Slot 255, which no entry expects
task automatic skippedStore();
    emit(sFormat(5'd0, 5'd0, 12'd2040));
endtask

task automatic regOp(input string name, input logic [2:0] funct3, input logic [6:0] funct7,
                     input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2,
                     input logic [63:0] value);
    emit(rFormat(funct3, funct7, rd, rs1, rs2));
    checkedStore(name, rd, value);
endtask

task automatic immOp(input string name, input logic [2:0] funct3, input logic [4:0] rd,
                     input logic [4:0] rs1, input logic [11:0] imm, input logic [63:0] value);
    emit(iFormat(7'h13, funct3, rd, rs1, imm));
    checkedStore(name, rd, value);
endtask

// Taken case jumps over a stray store, not-taken case falls into a checked one
task automatic branchPair(input string name, input logic [2:0] funct3,
                          input logic [4:0] takenRs1, input logic [4:0] takenRs2,
                          input logic [4:0] notRs1, input logic [4:0] notRs2);
    emit(bFormat(funct3, takenRs1, takenRs2, 13'd8));
    skippedStore();
    emit(bFormat(funct3, notRs1, notRs2, 13'd8));
    checkedStore({name, " not taken"}, 5'd3, 64'd5);  // x3 holds 5
endtask

task automatic loadProgram();
    for (int i = 0; i < 2 ** (`PC_W - 2); i++)
        rom[i] = `NOP_INSTR;
    progPc    = 0;
    storeSlot = 0;
    emit(iFormat(7'h13, 3'd0, 5'd1, 5'd0, 12'hFF9));  // x1 = -7
    emit(iFormat(7'h13, 3'd0, 5'd2, 5'd0, 12'd12));   // x2 = 12
    regOp("add", 3'd0, 7'h00, 5'd3, 5'd1, 5'd2, 64'd5);
    regOp("sub", 3'd0, 7'h20, 5'd4, 5'd1, 5'd2, 64'hFFFF_FFFF_FFFF_FFED);
    regOp("and", 3'd7, 7'h00, 5'd5, 5'd1, 5'd2, 64'd8);
    regOp("or", 3'd6, 7'h00, 5'd6, 5'd1, 5'd2, 64'hFFFF_FFFF_FFFF_FFFD);
    regOp("xor", 3'd4, 7'h00, 5'd7, 5'd1, 5'd2, 64'hFFFF_FFFF_FFFF_FFF5);
    regOp("slt", 3'd2, 7'h00, 5'd8, 5'd1, 5'd2, 64'd1);
    regOp("sltu", 3'd3, 7'h00, 5'd9, 5'd1, 5'd2, 64'd0);
    regOp("sll", 3'd1, 7'h00, 5'd10, 5'd2, 5'd1, 64'h1800_0000_0000_0000);  // Shift by 57
    regOp("srl", 3'd5, 7'h00, 5'd11, 5'd1, 5'd2, 64'h000F_FFFF_FFFF_FFFF);
    regOp("sra", 3'd5, 7'h20, 5'd12, 5'd1, 5'd2, 64'hFFFF_FFFF_FFFF_FFFF);
    immOp("addi", 3'd0, 5'd13, 5'd2, 12'hFEC, 64'hFFFF_FFFF_FFFF_FFF8);
    immOp("andi", 3'd7, 5'd14, 5'd1, 12'h0FF, 64'h0000_0000_0000_00F9);
    immOp("ori", 3'd6, 5'd15, 5'd2, 12'hF00, 64'hFFFF_FFFF_FFFF_FF0C);
    immOp("xori", 3'd4, 5'd16, 5'd1, 12'hFFF, 64'd6);
    immOp("slti", 3'd2, 5'd17, 5'd1, 12'hFFA, 64'd1);
    immOp("sltiu", 3'd3, 5'd18, 5'd2, 12'hFFF, 64'd1);
    immOp("slli", 3'd1, 5'd19, 5'd2, 12'h03C, 64'hC000_0000_0000_0000);
    immOp("srli", 3'd5, 5'd20, 5'd1, 12'h03C, 64'h0000_0000_0000_000F);
    immOp("srai", 3'd5, 5'd21, 5'd1, 12'h401, 64'hFFFF_FFFF_FFFF_FFFC);
    // Forwarding at distance 1 and 2
    emit(rFormat(3'd0, 7'h00, 5'd22, 5'd2, 5'd2));
    emit(iFormat(7'h13, 3'd0, 5'd23, 5'd0, 12'd1));
    emit(rFormat(3'd0, 7'h00, 5'd24, 5'd22, 5'd23));
    emit(iFormat(7'h13, 3'd0, 5'd25, 5'd24, 12'd100));
    checkedStore("forward add", 5'd24, 64'd25);
    checkedStore("forward chain", 5'd25, 64'd125);
    // Load-use, each ld feeds the very next instruction
    emit(iFormat(7'h03, 3'd3, 5'd26, 5'd0, 12'd800));
    emit(iFormat(7'h13, 3'd0, 5'd27, 5'd26, 12'd1));
    checkedStore("load-use addi", 5'd27, 64'hA000_0064_0000_0065);
    emit(iFormat(7'h03, 3'd3, 5'd28, 5'd0, 12'd0));  // Slot 0 holds the add result
    emit(rFormat(3'd0, 7'h00, 5'd29, 5'd28, 5'd28));
    checkedStore("load-use add", 5'd29, 64'd10);
    emit(iFormat(7'h03, 3'd3, 5'd30, 5'd0, 12'd808));
    checkedStore("load-use store", 5'd30, 64'hA000_0065_0000_0065);
    branchPair("beq", 3'd0, 5'd3, 5'd3, 5'd1, 5'd2);
    branchPair("bne", 3'd1, 5'd1, 5'd2, 5'd2, 5'd2);
    branchPair("blt", 3'd4, 5'd1, 5'd2, 5'd2, 5'd1);
    branchPair("bge", 3'd5, 5'd2, 5'd1, 5'd1, 5'd2);
    branchPair("bltu", 3'd6, 5'd2, 5'd1, 5'd1, 5'd2);
    branchPair("bgeu", 3'd7, 5'd1, 5'd2, 5'd2, 5'd1);
    // Jumps sit at a fixed address so the links are known, NOPs run up to it
    progPc = 'h200;
    emit(jFormat(5'd5, 21'd12));
    skippedStore();
    skippedStore();
    checkedStore("jal link", 5'd5, 64'h204);
    emit(iFormat(7'h13, 3'd0, 5'd6, 5'd0, 12'h225));
    emit(iFormat(7'h67, 3'd0, 5'd7, 5'd6, 12'd3));  // 0x228 once bit 0 is cleared
    repeat (4) skippedStore();
    checkedStore("jalr link", 5'd7, 64'h218);
    emit(uFormat(5'd8, 20'hABCDE));
    checkedStore("lui negative", 5'd8, 64'hFFFF_FFFF_ABCD_E000);
    emit(uFormat(5'd9, 20'h12345));
    checkedStore("lui positive", 5'd9, 64'h0000_0000_1234_5000);
    emit(iFormat(7'h13, 3'd0, 5'd0, 5'd0, 12'd77));
    emit(rFormat(3'd0, 7'h00, 5'd10, 5'd0, 5'd0));
    checkedStore("x0 read after write", 5'd10, 64'd0);
    checkedStore("x0 store", 5'd0, 64'd0);
    emit(jFormat(5'd0, 21'd0));  // Park here
    numStores = storeSlot;
endtask

`endif

// File: dv/rvCoreTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_config.svh"

module rvCoreTb;
    logic               CLK = 1'b0;
    logic               rstN = 1'b0;
    logic [`ILEN-1:0]   instr;
    logic [`XLEN-1:0]   ramReadData;
    logic [`PC_W-3:0]   instrAddr;
    logic [`RAM_AW-1:0] ramAddr;
    logic [`XLEN-1:0]   ramWriteData;
    logic               ramWriteEnable;

    logic [`ILEN-1:0]   rom [0:(2 ** (`PC_W - 2)) - 1];
    logic [`XLEN-1:0]   ram [0:(2 ** `RAM_AW) - 1];

    // Expected stores in program order
    string              expName [0:63];
    logic [`RAM_AW-1:0] expAddr [0:63];
    logic [`XLEN-1:0]   expData [0:63];
    int                 numStores = 0;
    int                 storeIdx = 0;
    int                 errors = 0;
    int                 cycleCount = 0;
    int                 progPc;
    int                 storeSlot;
    int                 waitCycles;

    `include "tbProgram.svh"

    rvCore rvCore_inst (
        .CLK(CLK),
        .rstN(rstN),
        .instr(instr),
        .ramReadData(ramReadData),
        .instrAddr(instrAddr),
        .ramAddr(ramAddr),
        .ramWriteData(ramWriteData),
        .ramWriteEnable(ramWriteEnable)
    );

    assign instr       = rom[instrAddr];  // Combinational ROM
    assign ramReadData = ram[ramAddr];

    initial begin
        forever #2 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycleCount <= cycleCount + 1;
        if (ramWriteEnable)
            ram[ramAddr] <= ramWriteData;
        if (rstN && ramWriteEnable)
            storeIdx <= storeIdx + 1;  // Assertions below see the old index
    end

    assert property (@(posedge CLK) disable iff (!rstN)
            ramWriteEnable && storeIdx < numStores
            |-> ramAddr == expAddr[storeIdx] && ramWriteData == expData[storeIdx])
        else begin
            errors++;
            $display("Error %s: expected slot %0d data %h, actual slot %0d data %h",
                     expName[$sampled(storeIdx)], expAddr[$sampled(storeIdx)],
                     expData[$sampled(storeIdx)], $sampled(ramAddr), $sampled(ramWriteData));
        end

    assert property (@(posedge CLK) disable iff (!rstN) ramWriteEnable |-> storeIdx < numStores)
        else begin
            errors++;
            $display("A store to slot %0d came after the last expected store",
                     $sampled(ramAddr));
        end

    // Pipeline state is unknown before the first edge
    assert property (@(negedge CLK) !rstN && cycleCount > 0 |-> !ramWriteEnable)
        else begin
            errors++;
            $display("RAM write enable was high during reset");
        end

    // Reset PC is zero
    assert property (@(negedge CLK) !rstN && cycleCount > 0 |-> instrAddr == '0)
        else begin
            errors++;
            $display("Fetch address was not the reset address during reset");
        end

    initial begin
        for (int i = 0; i < 2 ** `RAM_AW; i++)
            ram[i] = 64'hA000_0000_0000_0000 + 64'(i) * 64'h0000_0001_0000_0001;
        loadProgram();
        repeat (5) @(negedge CLK);
        rstN = 1'b1;

        waitCycles = 0;
        while (storeIdx < numStores && waitCycles < 2000) begin
            @(negedge CLK);
            waitCycles++;
        end
        if (storeIdx < numStores) begin
            errors++;
            $display("Timed out with %0d of %0d expected stores seen", storeIdx, numStores);
        end

        // Let a stray late store still reach the checker
        waitCycles = 0;
        while (waitCycles < 20) begin
            @(negedge CLK);
            waitCycles++;
        end

        $display("Stores seen %0d of %0d, errors %0d", storeIdx, numStores, errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: core/rvCore.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_config.svh"

module rvCore import rvPkg::*; (
    input  wire logic                  CLK,
    input  wire logic                  rstN,
    input  wire logic [`ILEN-1:0]      instr,
    input  wire logic [`XLEN-1:0]      ramReadData,
    output logic      [`PC_W-3:0]      instrAddr,
    output logic      [`RAM_AW-1:0]    ramAddr,
    output logic      [`XLEN-1:0]      ramWriteData,
    output logic                       ramWriteEnable
);
    logic [`ILEN-1:0]   decInstr;
    logic [`PC_W-1:0]   decPc;

    // Decode to execute
    instrClassE         exClass;
    aluOpE              exAluOp;
    wbSelE              exWbSel;
    logic [`REG_AW-1:0] exRs1;
    logic [`REG_AW-1:0] exRs2;
    logic [`REG_AW-1:0] exRd;
    logic [`XLEN-1:0]   exImm;
    logic [`PC_W-1:0]   exPc;
    logic [2:0]         exFunct3;
    logic               exIsBranch;
    logic               exIsJump;

    logic [`REG_AW-1:0] rs1;
    logic [`REG_AW-1:0] rs2;
    logic [`XLEN-1:0]   rs1Data;
    logic [`XLEN-1:0]   rs2Data;
    logic               redirect;
    logic [`PC_W-1:0]   redirectPc;

    // Execute to memory
    logic [`XLEN-1:0]   memAluResult;
    logic [`XLEN-1:0]   memStoreData;
    logic [`REG_AW-1:0] memRd;
    wbSelE              memWbSel;
    logic [`PC_W-1:0]   memPc;
    logic               memIsStore;

    logic [`XLEN-1:0]   memResult;
    logic               rfWriteEn;
    logic [`REG_AW-1:0] rfWriteAddr;
    logic [`XLEN-1:0]   rfWriteData;
    logic [`REG_AW-1:0] wbRd;

    logic               loadStall;
    logic               ctrlHold;
    logic [1:0]         fwdA;
    logic [1:0]         fwdB;

    fetchStage fetchStage_inst (
        .CLK(CLK), .rstN(rstN), .instr(instr), .loadStall(loadStall), .ctrlHold(ctrlHold),
        .redirect(redirect), .redirectPc(redirectPc), .instrAddr(instrAddr),
        .decInstr(decInstr), .decPc(decPc)
    );

    decodeStage decodeStage_inst (
        .CLK(CLK), .rstN(rstN), .decInstr(decInstr), .decPc(decPc), .loadStall(loadStall),
        .exClass(exClass), .exAluOp(exAluOp), .exWbSel(exWbSel), .exRs1(exRs1),
        .exRs2(exRs2), .exRd(exRd), .exImm(exImm), .exPc(exPc), .exFunct3(exFunct3),
        .exIsBranch(exIsBranch), .exIsJump(exIsJump)
    );

    regFile regFile_inst (
        .CLK(CLK), .rstN(rstN), .rs1(rs1), .rs2(rs2), .rfWriteEn(rfWriteEn),
        .rfWriteAddr(rfWriteAddr), .rfWriteData(rfWriteData),
        .rs1Data(rs1Data), .rs2Data(rs2Data)
    );

    hazardUnit hazardUnit_inst (
        .decInstr(decInstr), .exClass(exClass), .exRd(exRd), .exRs1(exRs1), .exRs2(exRs2),
        .exIsBranch(exIsBranch), .exIsJump(exIsJump), .memRd(memRd), .memWbSel(memWbSel),
        .wbRd(wbRd), .wbWriteEn(rfWriteEn), .loadStall(loadStall), .ctrlHold(ctrlHold),
        .fwdA(fwdA), .fwdB(fwdB)
    );

    executeStage executeStage_inst (
        .CLK(CLK), .rstN(rstN), .exClass(exClass), .exAluOp(exAluOp), .exWbSel(exWbSel),
        .exRs1(exRs1), .exRs2(exRs2), .exRd(exRd), .exImm(exImm), .exPc(exPc),
        .exFunct3(exFunct3), .exIsBranch(exIsBranch), .exIsJump(exIsJump),
        .rs1Data(rs1Data), .rs2Data(rs2Data), .fwdA(fwdA), .fwdB(fwdB),
        .memResult(memResult), .wbResult(rfWriteData), .rs1(rs1), .rs2(rs2),
        .redirect(redirect), .redirectPc(redirectPc), .memAluResult(memAluResult),
        .memStoreData(memStoreData), .memRd(memRd), .memWbSel(memWbSel), .memPc(memPc),
        .memIsStore(memIsStore)
    );

    memWbStage memWbStage_inst (
        .CLK(CLK), .rstN(rstN), .memAluResult(memAluResult), .memStoreData(memStoreData),
        .memRd(memRd), .memWbSel(memWbSel), .memPc(memPc), .memIsStore(memIsStore),
        .ramReadData(ramReadData), .ramAddr(ramAddr), .ramWriteData(ramWriteData),
        .ramWriteEnable(ramWriteEnable), .memResult(memResult), .rfWriteEn(rfWriteEn),
        .rfWriteAddr(rfWriteAddr), .rfWriteData(rfWriteData), .wbRd(wbRd)
    );

endmodule

`default_nettype wire

// File: core/memWbStage.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_config.svh"

module memWbStage import rvPkg::*; (
    input  wire logic               CLK,
    input  wire logic               rstN,
    input  wire logic [`XLEN-1:0]   memAluResult,
    input  wire logic [`XLEN-1:0]   memStoreData,
    input  wire logic [`REG_AW-1:0] memRd,
    input  wire wbSelE              memWbSel,
    input  wire logic [`PC_W-1:0]   memPc,
    input  wire logic               memIsStore,
    input  wire logic [`XLEN-1:0]   ramReadData,
    output logic      [`RAM_AW-1:0] ramAddr,
    output logic      [`XLEN-1:0]   ramWriteData,
    output logic                    ramWriteEnable,
    output logic      [`XLEN-1:0]   memResult,
    output logic                    rfWriteEn,
    output logic      [`REG_AW-1:0] rfWriteAddr,
    output logic      [`XLEN-1:0]   rfWriteData,
    output logic      [`REG_AW-1:0] wbRd
);
    logic [`XLEN-1:0] linkAddr;

    assign linkAddr = {{(`XLEN-`PC_W){1'b0}}, memPc} + `XLEN'(4);

    // Doubleword RAM, byte address bits 2:0 dropped
    assign ramAddr        = memAluResult[`RAM_AW+2:3];
    assign ramWriteData   = memStoreData;
    assign ramWriteEnable = memIsStore;

    assign memResult = (memWbSel == wbLink) ? linkAddr : memAluResult;

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            rfWriteEn   <= 1'b0;
            rfWriteAddr <= '0;
        end else begin
            rfWriteEn   <= memWbSel != wbNone && memRd != '0;  // Drop writes to x0
            rfWriteAddr <= memRd;
        end
    end

    always_ff @(posedge CLK) begin
        rfWriteData <= (memWbSel == wbMem) ? ramReadData : memResult;
    end

    assign wbRd = rfWriteAddr;

endmodule

`default_nettype wire

// File: core/executeStage.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_config.svh"

module executeStage import rvPkg::*; (
    input  wire logic               CLK,
    input  wire logic               rstN,
    input  wire instrClassE         exClass,
    input  wire aluOpE              exAluOp,
    input  wire wbSelE              exWbSel,
    input  wire logic [`REG_AW-1:0] exRs1,
    input  wire logic [`REG_AW-1:0] exRs2,
    input  wire logic [`REG_AW-1:0] exRd,
    input  wire logic [`XLEN-1:0]   exImm,
    input  wire logic [`PC_W-1:0]   exPc,
    input  wire logic [2:0]         exFunct3,
    input  wire logic               exIsBranch,
    input  wire logic               exIsJump,
    input  wire logic [`XLEN-1:0]   rs1Data,
    input  wire logic [`XLEN-1:0]   rs2Data,
    input  wire logic [1:0]         fwdA,
    input  wire logic [1:0]         fwdB,
    input  wire logic [`XLEN-1:0]   memResult,
    input  wire logic [`XLEN-1:0]   wbResult,
    output logic      [`REG_AW-1:0] rs1,
    output logic      [`REG_AW-1:0] rs2,
    output logic                    redirect,
    output logic      [`PC_W-1:0]   redirectPc,
    output logic      [`XLEN-1:0]   memAluResult,
    output logic      [`XLEN-1:0]   memStoreData,
    output logic      [`REG_AW-1:0] memRd,
    output wbSelE                   memWbSel,
    output logic      [`PC_W-1:0]   memPc,
    output logic                    memIsStore
);
    logic [`XLEN-1:0] opA;
    logic [`XLEN-1:0] rs2Val;
    logic [`XLEN-1:0] opB;
    logic [`XLEN-1:0] aluResult;
    logic [`XLEN-1:0] target;
    logic             taken;

    function automatic logic [`XLEN-1:0] fwdMux(input logic [1:0] sel,
                                                  input logic [`XLEN-1:0] regVal);
        case (sel)
            2'd1:    return memResult;
            2'd2:    return wbResult;
            default: return regVal;
        endcase
    endfunction

    // Register file is read in this stage
    assign rs1 = exRs1;
    assign rs2 = exRs2;

    assign opA    = fwdMux(fwdA, rs1Data);
    assign rs2Val = fwdMux(fwdB, rs2Data);
    assign opB    = (exClass inside {clsReg, clsBranch}) ? rs2Val : exImm;

    always_comb begin
        case (exAluOp)
            aluAdd:   aluResult = opA + opB;
            aluSub:   aluResult = opA - opB;
            aluAnd:   aluResult = opA & opB;
            aluOr:    aluResult = opA | opB;
            aluXor:   aluResult = opA ^ opB;
            aluSll:   aluResult = opA << opB[5:0];
            aluSrl:   aluResult = opA >> opB[5:0];
            aluSra:   aluResult = $signed(opA) >>> opB[5:0];
            aluSlt:   aluResult = `XLEN'($signed(opA) < $signed(opB));
            aluSltu:  aluResult = `XLEN'(opA < opB);
            aluPassB: aluResult = opB;  // lui
            default:  aluResult = '0;
        endcase
    end

    always_comb begin
        case (exFunct3)
            3'd0:    taken = opA == rs2Val;
            3'd1:    taken = opA != rs2Val;
            3'd4:    taken = $signed(opA) < $signed(rs2Val);
            3'd5:    taken = $signed(opA) >= $signed(rs2Val);
            3'd6:    taken = opA < rs2Val;
            3'd7:    taken = opA >= rs2Val;
            default: taken = 1'b0;
        endcase
    end

    // jalr is the only jump carrying the I-type class
    assign target = (exIsJump && exClass == clsImm)
                    ? (aluResult & ~`XLEN'(1))
                    : {{(`XLEN-`PC_W){1'b0}}, exPc} + exImm;

    assign redirect   = (exIsBranch && taken) || exIsJump;
    assign redirectPc = target[`PC_W-1:0];

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            memWbSel   <= wbNone;
            memIsStore <= 1'b0;
            memRd      <= '0;
        end else begin
            memWbSel   <= exWbSel;
            memIsStore <= exClass == clsStore;
            memRd      <= exRd;
        end
    end

    always_ff @(posedge CLK) begin
        memAluResult <= aluResult;
        memStoreData <= rs2Val;
        memPc        <= exPc;
    end

endmodule

`default_nettype wire

// File: core/hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_config.svh"

module hazardUnit import rvPkg::*; (
    input  wire logic [`ILEN-1:0]   decInstr,
    input  wire instrClassE         exClass,
    input  wire logic [`REG_AW-1:0] exRd,
    input  wire logic [`REG_AW-1:0] exRs1,
    input  wire logic [`REG_AW-1:0] exRs2,
    input  wire logic               exIsBranch,
    input  wire logic               exIsJump,
    input  wire logic [`REG_AW-1:0] memRd,
    input  wire wbSelE              memWbSel,
    input  wire logic [`REG_AW-1:0] wbRd,
    input  wire logic               wbWriteEn,
    output logic                    loadStall,
    output logic                    ctrlHold,
    output logic      [1:0]         fwdA,
    output logic      [1:0]         fwdB
);
    instrClassE         decClass;
    logic [`REG_AW-1:0] decRs1;
    logic [`REG_AW-1:0] decRs2;
    logic               memFwdOk;

    assign decClass = classOf(decInstr[6:0]);
    assign decRs1   = decInstr[19:15];
    assign decRs2   = decInstr[24:20];

    // Load result is not ready until writeback
    assign loadStall = exClass == clsLoad && exRd != '0
                       && ((usesRs1(decClass) && decRs1 == exRd)
                           || (usesRs2(decClass) && decRs2 == exRd));

    assign ctrlHold = decInstr[6:0] inside {opBranch, opJal, opJalr}
                      || exIsBranch || exIsJump;

    // A load in memory never qualifies
    assign memFwdOk = memWbSel inside {wbAlu, wbLink} && memRd != '0;

    // 1 takes memory, 2 takes writeback, memory wins
    always_comb begin
        fwdA = 2'd0;
        fwdB = 2'd0;
        if (usesRs1(exClass) && memFwdOk && exRs1 == memRd)
            fwdA = 2'd1;
        else if (usesRs1(exClass) && wbWriteEn && exRs1 == wbRd)
            fwdA = 2'd2;
        if (usesRs2(exClass) && memFwdOk && exRs2 == memRd)
            fwdB = 2'd1;
        else if (usesRs2(exClass) && wbWriteEn && exRs2 == wbRd)
            fwdB = 2'd2;
    end

endmodule

`default_nettype wire

// File: core/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_config.svh"

module decodeStage import rvPkg::*; (
    input  wire logic               CLK,
    input  wire logic               rstN,
    input  wire logic [`ILEN-1:0]   decInstr,
    input  wire logic [`PC_W-1:0]   decPc,
    input  wire logic               loadStall,
    output instrClassE              exClass,
    output aluOpE                   exAluOp,
    output wbSelE                   exWbSel,
    output logic      [`REG_AW-1:0] exRs1,
    output logic      [`REG_AW-1:0] exRs2,
    output logic      [`REG_AW-1:0] exRd,
    output logic      [`XLEN-1:0]   exImm,
    output logic      [`PC_W-1:0]   exPc,
    output logic      [2:0]         exFunct3,
    output logic                    exIsBranch,
    output logic                    exIsJump
);
    opcodeE             op;
    logic [2:0]         funct3;
    logic               altFn;  // Bit 30 selects sub and sra
    logic [`XLEN-1:0]   immI;
    logic [`XLEN-1:0]   immS;
    logic [`XLEN-1:0]   immB;
    logic [`XLEN-1:0]   immJ;
    logic [`XLEN-1:0]   immU;
    aluOpE              fnOp;
    aluOpE              aluOp;
    wbSelE              wbSel;
    logic [`XLEN-1:0]   imm;
    logic [`REG_AW-1:0] rs1;
    logic [`REG_AW-1:0] rs2;
    logic [`REG_AW-1:0] rd;
    logic               isBranch;
    logic               isJump;

    assign op     = opcodeE'(decInstr[6:0]);
    assign funct3 = decInstr[14:12];
    assign altFn  = decInstr[30];

    assign immI = {{(`XLEN-12){decInstr[31]}}, decInstr[31:20]};
    assign immS = {{(`XLEN-12){decInstr[31]}}, decInstr[31:25], decInstr[11:7]};
    assign immB = {{(`XLEN-12){decInstr[31]}}, decInstr[7], decInstr[30:25],
                   decInstr[11:8], 1'b0};
    assign immJ = {{(`XLEN-20){decInstr[31]}}, decInstr[19:12], decInstr[20],
                   decInstr[30:21], 1'b0};
    assign immU = {{(`XLEN-32){decInstr[31]}}, decInstr[31:12], 12'b0};

    always_comb begin
        case (funct3)
            3'd0:    fnOp = (op == opReg && altFn) ? aluSub : aluAdd;  // No subi
            3'd1:    fnOp = aluSll;
            3'd2:    fnOp = aluSlt;
            3'd3:    fnOp = aluSltu;
            3'd4:    fnOp = aluXor;
            3'd5:    fnOp = altFn ? aluSra : aluSrl;
            3'd6:    fnOp = aluOr;
            default: fnOp = aluAnd;
        endcase
    end

    always_comb begin
        aluOp    = aluAdd;  // Address adder for loads, stores and jalr
        wbSel    = wbNone;
        imm      = immI;
        rs1      = decInstr[19:15];
        rs2      = decInstr[24:20];
        rd       = decInstr[11:7];
        isBranch = 1'b0;
        isJump   = 1'b0;
        case (op)
            opReg, opImm: begin
                aluOp = fnOp;
                wbSel = wbAlu;
            end
            opLoad:  wbSel = wbMem;
            opStore: imm = immS;
            opBranch: begin
                imm      = immB;
                isBranch = 1'b1;
            end
            opJal: begin
                imm    = immJ;
                wbSel  = wbLink;
                isJump = 1'b1;
            end
            opJalr: begin
                wbSel  = wbLink;
                isJump = 1'b1;
            end
            opLui: begin
                aluOp = aluPassB;
                wbSel = wbAlu;
                imm   = immU;
            end
            default: begin  // Unknown opcode runs as a NOP
                rs1 = '0;
                rs2 = '0;
                rd  = '0;
            end
        endcase
    end

    always_ff @(posedge CLK) begin
        if (!rstN || loadStall) begin
            exClass    <= clsImm;
            exAluOp    <= aluAdd;
            exWbSel    <= wbNone;
            exRs1      <= '0;
            exRs2      <= '0;
            exRd       <= '0;
            exIsBranch <= 1'b0;
            exIsJump   <= 1'b0;
        end else begin
            exClass    <= classOf(decInstr[6:0]);
            exAluOp    <= aluOp;
            exWbSel    <= wbSel;
            exRs1      <= rs1;
            exRs2      <= rs2;
            exRd       <= rd;
            exIsBranch <= isBranch;
            exIsJump   <= isJump;
        end
    end

    always_ff @(posedge CLK) begin
        exImm    <= imm;
        exPc     <= decPc;
        exFunct3 <= funct3;
    end

    // The stalled instruction comes back on the next cycle
    assert property (@(posedge CLK) disable iff (!rstN) loadStall |=> $stable(decInstr))
        else $error("decode instruction changed across a load-use stall");

endmodule

`default_nettype wire

// File: core/fetchStage.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_config.svh"

module fetchStage (
    input  wire logic             CLK,
    input  wire logic             rstN,
    input  wire logic [`ILEN-1:0] instr,
    input  wire logic             loadStall,
    input  wire logic             ctrlHold,
    input  wire logic             redirect,
    input  wire logic [`PC_W-1:0] redirectPc,
    output logic      [`PC_W-3:0] instrAddr,
    output logic      [`ILEN-1:0] decInstr,
    output logic      [`PC_W-1:0] decPc
);
    logic [`PC_W-1:0] pc;

    assign instrAddr = pc[`PC_W-1:2];  // ROM is word indexed

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            pc       <= `RESET_PC;
            decInstr <= `NOP_INSTR;
        end else if (redirect) begin
            pc       <= redirectPc;
            decInstr <= `NOP_INSTR;  // Squash the fall-through fetch
        end else if (ctrlHold && !loadStall) begin
            decInstr <= `NOP_INSTR;  // Bubble until the transfer resolves
        end else if (!loadStall) begin
            pc       <= pc + `PC_W'(4);
            decInstr <= instr;
        end
    end

    always_ff @(posedge CLK) begin
        if (!loadStall && !ctrlHold && !redirect)
            decPc <= pc;
    end

    // A load sits in execute during a stall, so no transfer can resolve there
    assert property (@(posedge CLK) disable iff (!rstN) !(loadStall && redirect))
        else $error("redirect during load-use stall would drop the load");

endmodule

`default_nettype wire

// File: core/regFile.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_config.svh"

module regFile (
    input  wire logic               CLK,
    input  wire logic               rstN,
    input  wire logic [`REG_AW-1:0] rs1,
    input  wire logic [`REG_AW-1:0] rs2,
    input  wire logic               rfWriteEn,
    input  wire logic [`REG_AW-1:0] rfWriteAddr,
    input  wire logic [`XLEN-1:0]   rfWriteData,
    output logic      [`XLEN-1:0]   rs1Data,
    output logic      [`XLEN-1:0]   rs2Data
);
    // x0 has no storage
    logic [`XLEN-1:0] regs [1:(2**`REG_AW)-1];

    assign rs1Data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2Data = (rs2 == '0) ? '0 : regs[rs2];

    always_ff @(posedge CLK) begin
        if (rfWriteEn && rfWriteAddr != '0)
            regs[rfWriteAddr] <= rfWriteData;
    end

    // Writeback already filters rd of zero
    assert property (@(posedge CLK) disable iff (!rstN) !(rfWriteEn && rfWriteAddr == '0))
        else $error("register write enabled for x0");

endmodule

`default_nettype wire

// File: common/rvPkg.sv
`default_nettype none

package rvPkg;

    // Major opcodes of the kept RV64I subset
    typedef enum logic [6:0] {
        opLoad   = 7'h03,
        opImm    = 7'h13,
        opStore  = 7'h23,
        opReg    = 7'h33,
        opLui    = 7'h37,
        opBranch = 7'h63,
        opJalr   = 7'h67,
        opJal    = 7'h6F
    } opcodeE;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSll,
        aluSrl, aluSra, aluSlt, aluSltu, aluPassB
    } aluOpE;

    // Tells the hazard logic which source fields are real
    typedef enum logic [2:0] {
        clsReg, clsLoad, clsStore, clsImm, clsUpper, clsBranch, clsJump
    } instrClassE;

    typedef enum logic [1:0] {wbNone, wbAlu, wbLink, wbMem} wbSelE;

    function automatic instrClassE classOf(input logic [6:0] opcode);
        case (opcode)
            opReg:    return clsReg;
            opLoad:   return clsLoad;
            opStore:  return clsStore;
            opLui:    return clsUpper;
            opBranch: return clsBranch;
            opJal:    return clsJump;
            default:  return clsImm;  // jalr reads rs1 like an I-type
        endcase
    endfunction

    function automatic logic usesRs1(input instrClassE cls);
        return !(cls inside {clsUpper, clsJump});
    endfunction

    function automatic logic usesRs2(input instrClassE cls);
        return cls inside {clsReg, clsStore, clsBranch};
    endfunction

endpackage

`default_nettype wire

// File: common/rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// Data path and instruction widths
`define XLEN 64
`define ILEN 32

`define PC_W 10    // Byte PC, 1 KB of ROM
`define RAM_AW 10  // Doubleword index into the data RAM
`define REG_AW 5

// addi x0, x0, 0
`define NOP_INSTR 32'h0000_0013

`define RESET_PC '0

`endif
